// ==== dv/tb_tx_tasks.svh ====
/*
 * Tasks of tb_radio_tx, included inside the testbench module.
 * Every task starts and returns 2 ns after a rising clock edge.
 */
`ifndef TB_TX_TASKS_SVH
`define TB_TX_TASKS_SVH

////////////////////////////////////////////////////////////
// Helpers
////////////////////////////////////////////////////////////

task automatic next_cycle();
   @(posedge radio_clk);
   #2;
endtask

task automatic report_mismatch(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
   $display("[ERROR] %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
   mismatch_count++;
endtask

task automatic note_timeout(input string what);
   $display("[ERROR] %0t ns: timed out waiting for %s", $time, what);
   timeout_count++;
endtask

task automatic write_setting(input logic [7:0] offset, input logic [31:0] data);
   set_stb  = 1'b1;
   set_addr = SR_BASE + offset;
   set_data = data;
   next_cycle();
   set_stb  = 1'b0;
endtask

// Holds one beat on the host stream until the DUT takes it
task automatic drive_beat(input logic [63:0] data, input logic last);
   int waited;
   tx_tdata  = data;
   tx_tlast  = last;
   tx_tvalid = 1'b1;
   waited    = 0;
   @(negedge radio_clk);
   while (!tx_tready && waited < WAIT_LIMIT) begin
      @(negedge radio_clk);
      waited++;
   end
   if (!tx_tready) begin
      note_timeout("tx_tready on a host beat");
   end
   next_cycle();
endtask

// Header, optional timestamp, then nbeats random sample beats
task automatic send_packet(input logic has_time, input logic eob, input logic [11:0] seqnum,
                           input int nbeats, input logic [63:0] tstamp);
   tx_hdr_t     hdr;
   logic [63:0] beats [$];
   logic [31:0] smp_hi;
   logic [31:0] smp_lo;
   int          idx;
   hdr          = '0;
   hdr.has_time = has_time;
   hdr.eob      = eob;
   hdr.seqnum   = seqnum;
   hdr.length   = 16'(nbeats);
   hdr.sid      = 32'h0000_0100;
   beats.push_back(hdr);
   if (has_time) begin
      beats.push_back(tstamp);
   end
   for (idx = 0; idx < nbeats; idx++) begin
      smp_hi = $random(seed);
      smp_lo = $random(seed);
      beats.push_back({smp_hi, smp_lo});
      // Upper sample goes out first
      sent_smp.push_back(smp_hi);
      sent_smp.push_back(smp_lo);
   end
   for (idx = 0; idx < beats.size(); idx++) begin
      drive_beat(beats[idx], idx == beats.size() - 1);
   end
   tx_tvalid = 1'b0;
   tx_tlast  = 1'b0;
endtask

// Each sent sample must show for hold cycles, burst start within t_min..t_max
task automatic expect_tx_sequence(input int hold, input logic [63:0] t_min,
                                  input logic [63:0] t_max);
   int n;
   int waited;
   int idx;
   n      = sent_smp.size() * hold;
   waited = 0;
   while (!(tx_log.size() >= n && !run_tx) && waited < WAIT_LIMIT) begin
      next_cycle();
      waited++;
   end
   if (!(tx_log.size() >= n && !run_tx)) begin
      note_timeout("the tx sample sequence to finish");
   end
   if (tx_log.size() != n) begin
      report_mismatch("tx sample count", tx_log.size(), n);
   end
   for (idx = 0; idx < n && idx < tx_log.size(); idx++) begin
      if (tx_log[idx] !== sent_smp[idx / hold]) begin
         report_mismatch($sformatf("tx[%0d]", idx), tx_log[idx], sent_smp[idx / hold]);
      end
   end
   if (time_log.size() > 0 && (time_log[0] < t_min || time_log[0] > t_max)) begin
      $display("[ERROR] %0t ns: run_tx rose at vita_time %0d, expected %0d to %0d",
               $time, time_log[0], t_min, t_max);
      mismatch_count++;
   end
   if (tx !== idle_exp) begin
      report_mismatch("tx idle", tx, idle_exp);
   end
   tx_log.delete();
   time_log.delete();
   sent_smp.delete();
endtask

task automatic expect_response(input logic [31:0] code, input logic [11:0] seqnum);
   int          waited;
   tx_hdr_t     hdr;
   logic [63:0] word;
   waited = 0;
   while (resp_hdr_q.size() == 0 && waited < WAIT_LIMIT) begin
      next_cycle();
      waited++;
   end
   if (resp_hdr_q.size() == 0) begin
      note_timeout("a response packet");
   end else begin
      hdr  = resp_hdr_q.pop_front();
      word = resp_word_q.pop_front();
      if (hdr.sid !== resp_sid_exp) begin
         report_mismatch("resp hdr sid", hdr.sid, resp_sid_exp);
      end
      if (hdr.seqnum !== seqnum) begin
         report_mismatch("resp hdr seqnum", hdr.seqnum, seqnum);
      end
      if (hdr.length !== 16'd1) begin
         report_mismatch("resp hdr length", hdr.length, 1);
      end
      if (hdr.has_time !== 1'b0 || hdr.eob !== 1'b1) begin
         report_mismatch("resp hdr flags", {hdr.has_time, hdr.eob}, 2'b01);
      end
      if (word[31:0] !== code) begin
         report_mismatch("resp code", word[31:0], code);
      end
      if (word[43:32] !== seqnum) begin
         report_mismatch("resp seqnum", word[43:32], seqnum);
      end
   end
endtask

////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////

task automatic check_idle_value();
   int waited;
   if (tx !== 32'd0) begin
      report_mismatch("tx after reset", tx, 0);
   end
   if (run_tx !== 1'b0) begin
      report_mismatch("run_tx after reset", run_tx, 0);
   end
   if (tx_tready !== 1'b0) begin
      report_mismatch("tx_tready after reset", tx_tready, 0);
   end
   idle_exp = 32'h1234_5678;
   write_setting(SR_IDLE, idle_exp);
   waited = 0;
   while (tx !== idle_exp && waited < 8) begin
      next_cycle();
      waited++;
   end
   if (tx !== idle_exp) begin
      report_mismatch("tx", tx, idle_exp);
   end
endtask

task automatic run_untimed_burst();
   resp_sid_exp = 32'h0000_51d0;
   write_setting(SR_RESP_SID, resp_sid_exp);
   send_packet(1'b0, 1'b1, 12'h0a1, 3, 64'd0);
   expect_tx_sequence(1, 64'd0, '1);
   expect_response(ERR_ACK, 12'h0a1);
endtask

task automatic run_timed_burst();
   logic [63:0] tstamp;
   tstamp = vita_time + 64'd50;
   send_packet(1'b1, 1'b1, 12'h0b2, 2, tstamp);
   // Burst starts the cycle after the match, first sample one strobe later
   expect_tx_sequence(1, tstamp, tstamp + 64'd4);
   expect_response(ERR_ACK, 12'h0b2);
endtask

task automatic drop_late_packet();
   logic [63:0] tstamp;
   tstamp = vita_time - 64'd10;
   send_packet(1'b1, 1'b1, 12'h0c3, 2, tstamp);
   sent_smp.delete();
   expect_response(ERR_LATE, 12'h0c3);
   expect_tx_sequence(1, 64'd0, '1);
endtask

task automatic end_on_underflow();
   send_packet(1'b0, 1'b0, 12'h0d4, 2, 64'd0);
   expect_tx_sequence(1, 64'd0, '1);
   expect_response(ERR_UNDERFLOW, 12'h0d4);
endtask

task automatic pace_with_backpressure();
   write_setting(SR_DIVIDER, 32'd3);
   resp_tready = 1'b0;
   send_packet(1'b0, 1'b1, 12'h301, 2, 64'd0);
   send_packet(1'b0, 1'b1, 12'h302, 2, 64'd0);
   expect_tx_sequence(4, 64'd0, '1);
   if (resp_hdr_q.size() != 0) begin
      report_mismatch("responses during stall", resp_hdr_q.size(), 0);
   end
   if (resp_tvalid !== 1'b1) begin
      report_mismatch("resp_tvalid during stall", resp_tvalid, 1);
   end
   resp_tready = 1'b1;
   expect_response(ERR_ACK, 12'h301);
   expect_response(ERR_ACK, 12'h302);
endtask

`endif

// ==== dv/tb_radio_tx.sv ====
/*
 * Directed testbench for radio_tx with SR_BASE 216.
 * vita_time is a free-running cycle count. A monitor logs tx while run_tx
 * is high and collects response packets.
 */
`timescale 1ns/1ps

module tb_radio_tx;

   import radio_regs_pkg::*;
   import tx_stream_pkg::*;

   localparam logic [7:0] SR_BASE    = 8'd216;
   localparam int         WAIT_LIMIT = 400;

   logic        radio_clk;
   logic        arst_n;
   logic        set_stb;
   logic [7:0]  set_addr;
   logic [31:0] set_data;
   logic [63:0] vita_time;
   logic [31:0] tx;
   logic        run_tx;
   logic [63:0] tx_tdata;
   logic        tx_tlast;
   logic        tx_tvalid;
   logic        tx_tready;
   logic [63:0] resp_tdata;
   logic        resp_tlast;
   logic        resp_tvalid;
   logic        resp_tready;

   // Monitor logs
   logic [31:0] tx_log [$];
   logic [63:0] time_log [$];
   logic [63:0] resp_hdr_q [$];
   logic [63:0] resp_word_q [$];
   logic [63:0] resp_hdr_hold;
   logic        resp_second;

   // Expected state and bookkeeping
   logic [31:0] sent_smp [$];
   logic [31:0] idle_exp;
   logic [31:0] resp_sid_exp;
   integer      seed;
   int          mismatch_count;
   int          timeout_count;

   `include "tb_tx_tasks.svh"

   radio_tx #(.SR_BASE(SR_BASE)) u_dut (
      .radio_clk(radio_clk), .arst_n(arst_n),
      .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
      .vita_time(vita_time), .tx(tx), .run_tx(run_tx),
      .tx_tdata(tx_tdata), .tx_tlast(tx_tlast), .tx_tvalid(tx_tvalid),
      .tx_tready(tx_tready),
      .resp_tdata(resp_tdata), .resp_tlast(resp_tlast),
      .resp_tvalid(resp_tvalid), .resp_tready(resp_tready)
   );

   always #20 radio_clk = ~radio_clk;

   // Radio timebase, one tick per cycle
   always @(posedge radio_clk) begin
      #2;
      vita_time <= vita_time + 64'd1;
   end

   ////////////////////////////////////////////////////////////
   // Output monitor, sampled mid-cycle
   ////////////////////////////////////////////////////////////

   always @(negedge radio_clk) begin
      if (arst_n && run_tx) begin
         tx_log.push_back(tx);
         time_log.push_back(vita_time);
      end
      if (arst_n && resp_tvalid && resp_tready) begin
         // tlast only on the second beat
         if (resp_tlast !== resp_second) begin
            report_mismatch("resp_tlast", resp_tlast, resp_second);
         end
         if (!resp_second) begin
            resp_hdr_hold = resp_tdata;
         end else begin
            resp_hdr_q.push_back(resp_hdr_hold);
            resp_word_q.push_back(resp_tdata);
         end
         resp_second = !resp_second;
      end
   end

   initial begin
      #1_000_000;
      $display("Simulation ran too long and was stopped");
      $display("Testbench failed");
      $finish;
   end

   initial begin
      radio_clk      = 1'b0;
      arst_n         = 1'b0;
      set_stb        = 1'b0;
      set_addr       = '0;
      set_data       = '0;
      vita_time      = '0;
      tx_tdata       = '0;
      tx_tlast       = 1'b0;
      tx_tvalid      = 1'b0;
      resp_tready    = 1'b1;
      resp_second    = 1'b0;
      idle_exp       = '0;
      resp_sid_exp   = '0;
      seed           = 32'hcc01;
      mismatch_count = 0;
      timeout_count  = 0;
      repeat (5) @(posedge radio_clk);
      #2;
      arst_n = 1'b1;

      check_idle_value();
      run_untimed_burst();
      run_timed_burst();
      drop_late_packet();
      end_on_underflow();
      pace_with_backpressure();

      $display("Mismatches: %0d, timeouts: %0d", mismatch_count, timeout_count);
      if (mismatch_count == 0 && timeout_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+dv
rtl/radio_regs_pkg.sv
rtl/tx_stream_pkg.sv
rtl/tx_settings.sv
rtl/tx_deframer.sv
rtl/tx_timed_control.sv
rtl/tx_responder.sv
rtl/radio_tx.sv
dv/tb_radio_tx.sv

// ==== rtl/radio_regs_pkg.sv ====
/*
 * Settings-bus map and response codes of the transmit radio core.
 * Offsets are relative to the SR_BASE parameter of the top level.
 */
package radio_regs_pkg;

   ////////////////////////////////////////////////////////////
   // Settings-bus offsets
   ////////////////////////////////////////////////////////////

   // Idle value shown on tx outside a burst
   localparam logic [7:0] SR_IDLE     = 8'd0;
   // Strobe divider, one strobe every divider+1 cycles
   localparam logic [7:0] SR_DIVIDER  = 8'd1;
   // Stream id written into response headers
   localparam logic [7:0] SR_RESP_SID = 8'd2;

   ////////////////////////////////////////////////////////////
   // Programmed configuration
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      logic [31:0] idle;
      logic [15:0] divider;
      logic [31:0] resp_sid;
   } tx_cfg_t;

   ////////////////////////////////////////////////////////////
   // Response codes
   ////////////////////////////////////////////////////////////

   // End-of-burst sample has gone out
   localparam logic [31:0] ERR_ACK       = 32'd1;
   // Timed packet arrived after its time, packet dropped
   localparam logic [31:0] ERR_LATE      = 32'd2;
   // No sample ready at a strobe, burst ended
   localparam logic [31:0] ERR_UNDERFLOW = 32'd4;

endpackage

// ==== rtl/radio_tx.sv ====
/*
 * Transmit half of the radio core on radio_clk.
 * Samples pass to tx unchanged. There is no DUC and no readback.
 */
`timescale 1ns/1ps

module radio_tx #(
   parameter logic [7:0] SR_BASE = 8'd216
) (
   input  logic        radio_clk,
   input  logic        arst_n,
   // Settings bus
   input  logic        set_stb,
   input  logic [7:0]  set_addr,
   input  logic [31:0] set_data,
   input  logic [63:0] vita_time,
   // DAC side
   output logic [31:0] tx,
   output logic        run_tx,
   // Host sample stream
   input  logic [63:0] tx_tdata,
   input  logic        tx_tlast,
   input  logic        tx_tvalid,
   output logic        tx_tready,
   // Response stream
   output logic [63:0] resp_tdata,
   output logic        resp_tlast,
   output logic        resp_tvalid,
   input  logic        resp_tready
);

   import radio_regs_pkg::*;
   import tx_stream_pkg::*;

   tx_cfg_t  cfg;
   tx_item_t item;
   logic     item_valid;
   logic     item_ready;
   tx_evt_t  evt;
   logic     evt_valid;
   logic     evt_ready;

   tx_settings #(.SR_BASE(SR_BASE)) u_settings (
      .radio_clk(radio_clk), .arst_n(arst_n),
      .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
      .cfg(cfg)
   );

   tx_deframer u_deframer (
      .radio_clk(radio_clk), .arst_n(arst_n),
      .tx_tdata(tx_tdata), .tx_tlast(tx_tlast), .tx_tvalid(tx_tvalid),
      .tx_tready(tx_tready),
      .item(item), .item_valid(item_valid), .item_ready(item_ready)
   );

   tx_timed_control u_control (
      .radio_clk(radio_clk), .arst_n(arst_n), .cfg(cfg), .vita_time(vita_time),
      .item(item), .item_valid(item_valid), .item_ready(item_ready),
      .evt(evt), .evt_valid(evt_valid), .evt_ready(evt_ready),
      .tx(tx), .run_tx(run_tx)
   );

   tx_responder u_responder (
      .radio_clk(radio_clk), .arst_n(arst_n), .cfg(cfg),
      .evt(evt), .evt_valid(evt_valid), .evt_ready(evt_ready),
      .resp_tdata(resp_tdata), .resp_tlast(resp_tlast),
      .resp_tvalid(resp_tvalid), .resp_tready(resp_tready)
   );

endmodule

// ==== rtl/tx_deframer.sv ====
/*
 * Splits host packets into one item per sample, upper sample first.
 * The header length must be at least 1 and tlast must end the last sample beat.
 */
`timescale 1ns/1ps

module tx_deframer (
   input  logic                    radio_clk,
   input  logic                    arst_n,
   input  logic [63:0]             tx_tdata,
   input  logic                    tx_tlast,
   input  logic                    tx_tvalid,
   output logic                    tx_tready,
   output tx_stream_pkg::tx_item_t item,
   output logic                    item_valid,
   input  logic                    item_ready
);

   import tx_stream_pkg::*;

   typedef enum logic [1:0] {S_HDR, S_TIME, S_SMP} state_t;

   state_t      state;
   tx_beat_u    beat;
   tx_hdr_t     hdr_q;
   logic [63:0] time_q;
   logic [15:0] beats_left;
   logic        active;
   logic        first_pend;
   logic        second_pend;
   logic [31:0] second_smp;
   logic        second_eob;
   logic        beat_acc;
   logic        item_xfer;
   logic        last_beat;

   assign beat      = tx_tdata;
   assign item_xfer = item_valid && item_ready;
   assign last_beat = (beats_left == 16'd1);

   // Header and time beats never wait on the item side
   assign tx_tready = active &&
                      ((state != S_SMP) || (!second_pend && (!item_valid || item_ready)));
   assign beat_acc  = tx_tvalid && tx_tready;

   ////////////////////////////////////////////////////////////
   // Packet FSM and item handshake
   ////////////////////////////////////////////////////////////

   always_ff @(posedge radio_clk or negedge arst_n) begin
      if (!arst_n) begin
         state       <= S_HDR;
         active      <= 1'b0;
         beats_left  <= '0;
         first_pend  <= 1'b0;
         second_pend <= 1'b0;
         item_valid  <= 1'b0;
      end else begin
         active <= 1'b1;
         if (beat_acc) begin
            case (state)
               S_HDR: begin
                  beats_left <= beat.hdr.length;
                  first_pend <= 1'b1;
                  state      <= beat.hdr.has_time ? S_TIME : S_SMP;
               end
               S_TIME: begin
                  state <= S_SMP;
               end
               default: begin
                  beats_left <= beats_left - 16'd1;
                  first_pend <= 1'b0;
                  if (last_beat) begin
                     state <= S_HDR;
                  end
               end
            endcase
         end
         if (beat_acc && state == S_SMP) begin
            item_valid  <= 1'b1;
            second_pend <= 1'b1;
         end else if (item_xfer && second_pend) begin
            second_pend <= 1'b0;
         end else if (item_xfer) begin
            item_valid <= 1'b0;
         end
      end
   end

   // Header, timestamp and item payload
   always_ff @(posedge radio_clk) begin
      if (beat_acc && state == S_HDR) begin
         hdr_q <= beat.hdr;
      end
      if (beat_acc && state == S_TIME) begin
         time_q <= tx_tdata;
      end
      if (beat_acc && state == S_SMP) begin
         item.sample   <= beat.smp[1];
         item.first    <= first_pend;
         item.eob      <= 1'b0;
         item.has_time <= hdr_q.has_time;
         item.tstamp   <= time_q;
         item.seqnum   <= hdr_q.seqnum;
         second_smp    <= beat.smp[0];
         second_eob    <= last_beat && hdr_q.eob;
      end else if (item_xfer && second_pend) begin
         item.sample <= second_smp;
         item.first  <= 1'b0;
         item.eob    <= second_eob;
      end
   end

   // tlast comes with the final sample beat and nowhere else
   a_tlast_len : assert property (
      @(posedge radio_clk) disable iff (!arst_n)
      beat_acc |-> (tx_tlast == (state == S_SMP && last_beat))
   );

endmodule

// ==== rtl/tx_responder.sv ====
/*
 * Builds a two-beat response packet per control event.
 * Up to two events queue here while a third is being sent.
 */
`timescale 1ns/1ps

module tx_responder (
   input  logic                    radio_clk,
   input  logic                    arst_n,
   input  radio_regs_pkg::tx_cfg_t cfg,
   input  tx_stream_pkg::tx_evt_t  evt,
   input  logic                    evt_valid,
   output logic                    evt_ready,
   output logic [63:0]             resp_tdata,
   output logic                    resp_tlast,
   output logic                    resp_tvalid,
   input  logic                    resp_tready
);

   import tx_stream_pkg::*;

   tx_evt_t    q [0:1];
   tx_evt_t    head;
   tx_evt_t    cur;
   tx_hdr_t    hdr;
   logic       wr_ptr;
   logic       rd_ptr;
   logic [1:0] count;
   logic       push;
   logic       load;
   logic       pop;
   logic       wr;

   assign evt_ready = (count != 2'd2);
   assign push      = evt_valid && evt_ready;

   // Builder is free or sends its last beat in this cycle
   assign load = (!resp_tvalid || (resp_tready && resp_tlast)) && (count != 2'd0 || push);
   assign pop  = load && (count != 2'd0);
   // An event bypasses the empty queue
   assign wr   = push && !(load && count == 2'd0);
   assign head = (count != 2'd0) ? q[rd_ptr] : evt;

   always_comb begin
      hdr        = '0;
      hdr.eob    = 1'b1;
      hdr.seqnum = head.seqnum;
      hdr.length = 16'd1;
      hdr.sid    = cfg.resp_sid;
   end

   always_ff @(posedge radio_clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr      <= 1'b0;
         rd_ptr      <= 1'b0;
         count       <= '0;
         resp_tvalid <= 1'b0;
         resp_tlast  <= 1'b0;
      end else begin
         if (wr) begin
            wr_ptr <= ~wr_ptr;
         end
         if (pop) begin
            rd_ptr <= ~rd_ptr;
         end
         count <= count + 2'(wr) - 2'(pop);
         if (load) begin
            resp_tvalid <= 1'b1;
            resp_tlast  <= 1'b0;
         end else if (resp_tvalid && resp_tready) begin
            if (resp_tlast) begin
               resp_tvalid <= 1'b0;
            end else begin
               resp_tlast <= 1'b1;
            end
         end
      end
   end

   // Queue storage and outgoing beat
   always_ff @(posedge radio_clk) begin
      if (wr) begin
         q[wr_ptr] <= evt;
      end
      if (load) begin
         cur        <= head;
         resp_tdata <= hdr;
      end else if (resp_tvalid && resp_tready && !resp_tlast) begin
         resp_tdata <= {20'd0, cur.seqnum, cur.code};
      end
   end

   a_resp_hold : assert property (
      @(posedge radio_clk) disable iff (!arst_n)
      (resp_tvalid && !resp_tready) |=> (resp_tvalid && $stable(resp_tdata))
   );

endmodule

// ==== rtl/tx_settings.sv ====
/*
 * Register bank for the transmit settings.
 * A write lands in cfg one cycle after set_stb. Unknown addresses are ignored.
 */
`timescale 1ns/1ps

module tx_settings #(
   parameter logic [7:0] SR_BASE = 8'd216
) (
   input  logic                    radio_clk,
   input  logic                    arst_n,
   input  logic                    set_stb,
   input  logic [7:0]              set_addr,
   input  logic [31:0]             set_data,
   output radio_regs_pkg::tx_cfg_t cfg
);

   import radio_regs_pkg::*;

   // Absolute register addresses
   localparam logic [7:0] ADDR_IDLE     = SR_BASE + SR_IDLE;
   localparam logic [7:0] ADDR_DIVIDER  = SR_BASE + SR_DIVIDER;
   localparam logic [7:0] ADDR_RESP_SID = SR_BASE + SR_RESP_SID;

   always_ff @(posedge radio_clk or negedge arst_n) begin
      if (!arst_n) begin
         cfg <= '0;
      end else if (set_stb) begin
         case (set_addr)
            ADDR_IDLE: begin
               cfg.idle <= set_data;
            end
            ADDR_DIVIDER: begin
               cfg.divider <= set_data[15:0];
            end
            ADDR_RESP_SID: begin
               cfg.resp_sid <= set_data;
            end
            default: begin
            end
         endcase
      end
   end

   // A strobed write must carry a defined address
   a_addr_known : assert property (
      @(posedge radio_clk) disable iff (!arst_n)
      set_stb |-> !$isunknown(set_addr)
   );

endmodule

// ==== rtl/tx_stream_pkg.sv ====
/*
 * Packet and item formats of the transmit sample stream.
 * A sample word holds I in bits 31:16 and Q in bits 15:0.
 */
package tx_stream_pkg;

   ////////////////////////////////////////////////////////////
   // Host packet format
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      logic        has_time;
      logic        eob;
      logic [11:0] seqnum;
      // Sample beats that follow the header and timestamp
      logic [15:0] length;
      logic [31:0] sid;
      logic [1:0]  rsvd;
   } tx_hdr_t;

   // One 64-bit beat, read either as a header or as two samples
   typedef union packed {
      tx_hdr_t          hdr;
      // smp[1] is the upper sample and goes out first
      logic [1:0][31:0] smp;
   } tx_beat_u;

   ////////////////////////////////////////////////////////////
   // Deframer to timed control
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      logic [31:0] sample;
      // First sample of a packet
      logic        first;
      // Last sample of an end-of-burst packet
      logic        eob;
      logic        has_time;
      // Packet timestamp in vita_time units
      logic [63:0] tstamp;
      logic [11:0] seqnum;
   } tx_item_t;

   ////////////////////////////////////////////////////////////
   // Timed control to responder
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      // One of the ERR_ codes
      logic [31:0] code;
      logic [11:0] seqnum;
   } tx_evt_t;

endpackage

// ==== rtl/tx_timed_control.sv ====
/*
 * Starts bursts on time and paces samples out to tx with the strobe divider.
 * Reports ack, late and underflow events. A new burst waits until the event is taken.
 */
`timescale 1ns/1ps

module tx_timed_control (
   input  logic                    radio_clk,
   input  logic                    arst_n,
   input  radio_regs_pkg::tx_cfg_t cfg,
   input  logic [63:0]             vita_time,
   input  tx_stream_pkg::tx_item_t item,
   input  logic                    item_valid,
   output logic                    item_ready,
   output tx_stream_pkg::tx_evt_t  evt,
   output logic                    evt_valid,
   input  logic                    evt_ready,
   output logic [31:0]             tx,
   output logic                    run_tx
);

   import radio_regs_pkg::*;

   typedef enum logic [2:0] {S_IDLE, S_WAIT, S_RUN, S_DROP, S_REPORT} state_t;

   state_t      state;
   logic [15:0] cnt;
   logic [11:0] cur_seq;
   logic        eob_done;
   logic        start_ok;
   logic        late;
   logic        strobe;

   assign start_ok = item_valid && item.first && !evt_valid;
   assign late     = start_ok && item.has_time && (item.tstamp < vita_time);
   assign strobe   = (state == S_RUN) && (cnt == 16'd0);

   always_comb begin
      case (state)
         // Late first items and stray tail items are dropped
         S_IDLE:  item_ready = late || !item.first;
         S_DROP:  item_ready = !item.first;
         S_RUN:   item_ready = strobe && !eob_done;
         default: item_ready = 1'b0;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Burst FSM, strobe counter and tx register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge radio_clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= S_IDLE;
         cnt       <= '0;
         cur_seq   <= '0;
         eob_done  <= 1'b0;
         run_tx    <= 1'b0;
         tx        <= '0;
         evt       <= '0;
         evt_valid <= 1'b0;
      end else begin
         if (evt_valid && evt_ready) begin
            evt_valid <= 1'b0;
         end
         if (state != S_RUN) begin
            tx  <= cfg.idle;
            cnt <= '0;
         end else if (strobe) begin
            cnt <= cfg.divider;
         end else begin
            cnt <= cnt - 16'd1;
         end
         case (state)
            S_IDLE: begin
               eob_done <= 1'b0;
               if (late) begin
                  evt_valid  <= 1'b1;
                  evt.code   <= ERR_LATE;
                  evt.seqnum <= item.seqnum;
                  state      <= item.eob ? S_IDLE : S_DROP;
               end else if (start_ok) begin
                  state <= item.has_time ? S_WAIT : S_RUN;
               end
            end
            S_WAIT: begin
               if (vita_time >= item.tstamp) begin
                  state <= S_RUN;
               end
            end
            S_RUN: begin
               if (strobe && (eob_done || !item_valid)) begin
                  // Burst over, by eob or by a missing sample
                  run_tx     <= 1'b0;
                  tx         <= cfg.idle;
                  evt_valid  <= 1'b1;
                  evt.code   <= eob_done ? ERR_ACK : ERR_UNDERFLOW;
                  evt.seqnum <= cur_seq;
                  state      <= S_REPORT;
               end else if (strobe) begin
                  run_tx   <= 1'b1;
                  tx       <= item.sample;
                  cur_seq  <= item.seqnum;
                  eob_done <= item.eob;
               end
            end
            S_DROP: begin
               if (item_valid && (item.first || item.eob)) begin
                  state <= S_IDLE;
               end
            end
            default: begin
               if (evt_ready) begin
                  state <= S_IDLE;
               end
            end
         endcase
      end
   end

   // While an end-of-burst event waits, nothing is consumed or sent
   a_report_quiet : assert property (
      @(posedge radio_clk) disable iff (!arst_n)
      (state == S_REPORT) |-> (!item_ready && !run_tx && evt_valid)
   );

endmodule
